// ==== Makefile ====
SRCS := $(shell cat project.f)

obj_dir/Vtb_mac_unit: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mac_unit -f project.f -o Vtb_mac_unit

run: obj_dir/Vtb_mac_unit
	./obj_dir/Vtb_mac_unit +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== bench/mac_unit_chk.sv ====
// bound assertions on the mac output encoding and its reset value
`timescale 1ns/1ps

module mac_unit_chk import fp16_pkg::*; (
    input logic  clk,
    input logic  nRST,
    input fp16_t out_accumulate
);

    // assertion failures so far, read back by the testbench
    int unsigned fail_count = 0;

    // no unknown bits once out of reset
    out_known: assert property (@(posedge clk) disable iff (!nRST)
        !$isunknown(out_accumulate))
        else begin
            fail_count++;
            $error("out_accumulate has unknown bits after reset");
        end

    // cleared registers normalize to +0
    out_reset_zero: assert property (@(posedge clk) !nRST |-> out_accumulate == FP16_POS_ZERO)
        else begin
            fail_count++;
            $error("out_accumulate is not +0 during reset");
        end

    // all ones exponent only as +inf, never nan or -inf
    out_inf_only: assert property (@(posedge clk) disable iff (!nRST)
        out_accumulate.exp == 5'(FP16_EXP_MAX) |-> out_accumulate == FP16_POS_INF)
        else begin
            fail_count++;
            $error("out_accumulate has exponent 31 but is not +inf");
        end

endmodule

bind mac_unit mac_unit_chk chk_i (
    .clk            (clk),
    .nRST           (nRST),
    .out_accumulate (out_accumulate)
);

// ==== bench/tb_mac_unit.sv ====
// testbench for mac_unit: clock, reset, lfsr stimulus, reference model, compare and watchdog
`timescale 1ns/1ps

module tb_mac_unit import fp16_pkg::*; ();

    localparam int NUM_RANDOM  = 200;
    // two exact, two cancel, three zero, three saturation cases plus the random stream
    localparam int NUM_VECTORS = 10 + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_VECTORS + 16 + 10) * 100;

    logic        clk;
    logic        nRST;
    fp16_t       in_value;
    fp16_t       weight;
    fp16_t       in_accumulate;
    fp16_t       out_accumulate;

    // partial sum of the last issued pair, driven one cycle later
    logic [15:0] pending_acc;
    logic [15:0] lfsr_state;
    logic        started;
    event        issue_started;
    int          error_count;
    int          check_count;
    // expected results in issue order
    logic [15:0] exp_q[$];
    string       name_q[$];

    mac_unit mac_unit_i (
        .clk            (clk),
        .nRST           (nRST),
        .in_value       (in_value),
        .weight         (weight),
        .in_accumulate  (in_accumulate),
        .out_accumulate (out_accumulate)
    );

    always #50 clk = ~clk;

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[14:0], lfsr_state[15]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // random normal number, exponent kept inside 1..30
    task automatic random_normal(output logic [15:0] value);
        logic [15:0] sign_bits;
        logic [15:0] exp_bits;
        logic [15:0] frac_bits;
        take_bits(1, sign_bits);
        take_bits(5, exp_bits);
        take_bits(10, frac_bits);
        if (exp_bits[4:0] == 5'd31) begin
            exp_bits = 16'd30;
        end else if (exp_bits[4:0] == 5'd0) begin
            exp_bits = 16'd1;
        end
        value = {sign_bits[0], exp_bits[4:0], frac_bits[9:0]};
    endtask

    // a * b + c with truncation, flush to +0 and saturation to +inf
    function automatic logic [15:0] fp16_mac_ref(input logic [15:0] a, input logic [15:0] b,
                                                 input logic [15:0] c);
        logic [21:0] sig_prod;
        logic [15:0] p;
        logic [12:0] sig_p;
        logic [12:0] sig_c;
        logic [12:0] sig_big;
        logic [12:0] sig_small;
        logic [13:0] mag;
        logic        sign_big;
        logic        sign_small;
        logic        res_sign;
        int          e;
        p = 16'h0000;
        if (a[14:10] != 5'd0 && b[14:10] != 5'd0) begin
            sig_prod = 22'({1'b1, a[9:0]}) * 22'({1'b1, b[9:0]});
            e = int'(a[14:10]) + int'(b[14:10]) - 15;
            // product in [2,4) moves one place right
            if (sig_prod[21]) begin
                e       = e + 1;
                p[9:0]  = sig_prod[20:11];
            end else begin
                p[9:0]  = sig_prod[19:10];
            end
            if (e >= 31) begin
                return 16'h7C00;
            end
            if (e <= 0) begin
                p = 16'h0000;
            end else begin
                p[15:10] = {a[15] ^ b[15], e[4:0]};
            end
        end
        // 13 bit significands, zero exponent means zero
        sig_p = (p[14:10] == 5'd0) ? 13'd0 : {1'b1, p[9:0], 2'b00};
        sig_c = (c[14:10] == 5'd0) ? 13'd0 : {1'b1, c[9:0], 2'b00};
        // on a tie the accumulate side is the one shifted
        if (p[14:10] >= c[14:10]) begin
            e          = int'(p[14:10]);
            sig_big    = sig_p;
            sign_big   = p[15];
            sig_small  = sig_c >> (p[14:10] - c[14:10]);
            sign_small = c[15];
        end else begin
            e          = int'(c[14:10]);
            sig_big    = sig_c;
            sign_big   = c[15];
            sig_small  = sig_p >> (c[14:10] - p[14:10]);
            sign_small = p[15];
        end
        if (sign_big == sign_small) begin
            mag      = {1'b0, sig_big} + {1'b0, sig_small};
            res_sign = sign_big;
        end else if (sig_big >= sig_small) begin
            mag      = {1'b0, sig_big - sig_small};
            res_sign = sign_big;
        end else begin
            mag      = {1'b0, sig_small - sig_big};
            res_sign = sign_small;
        end
        if (mag == 14'd0) begin
            return 16'h0000;
        end
        if (mag[13]) begin
            mag = mag >> 1;
            e   = e + 1;
        end
        while (!mag[12]) begin
            mag = mag << 1;
            e   = e - 1;
        end
        if (e >= 31) begin
            return 16'h7C00;
        end
        if (e <= 0) begin
            return 16'h0000;
        end
        return {res_sign, e[4:0], mag[11:2]};
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch test=%s expected=0x%h actual=0x%h", name, expected, actual);
        end
    endtask

    // one operation per rising edge, in_accumulate trails its pair by a cycle
    task automatic issue_op(input string name, input logic [15:0] a, input logic [15:0] b,
                            input logic [15:0] c, input logic [15:0] expected);
        @(posedge clk);
        in_value      <= a;
        weight        <= b;
        in_accumulate <= pending_acc;
        pending_acc    = c;
        name_q.push_back(name);
        exp_q.push_back(expected);
        if (!started) begin
            started = 1'b1;
            -> issue_started;
        end
    endtask

    // last partial sum still has to enter the align stage
    task automatic flush_accumulate();
        @(posedge clk);
        in_value      <= '0;
        weight        <= '0;
        in_accumulate <= pending_acc;
    endtask

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        clk           = 1'b0;
        nRST          = 1'b0;
        // 2.0 * 3.0 held during reset, a register that misses reset shows a nonzero product
        in_value      = 16'h4000;
        weight        = 16'h4200;
        in_accumulate = '0;
        pending_acc   = '0;
        lfsr_state    = 16'd91;
        started       = 1'b0;
        error_count   = 0;
        check_count   = 0;
        // 16 rising edges in reset, output must stay +0
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("reset", 16'h0000, out_accumulate);
        end
        @(posedge clk);
        nRST <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("reset_release", 16'h0000, out_accumulate);
        end
        // small integers, exact
        issue_op("exact_2x3_plus_1", 16'h4000, 16'h4200, 16'h3C00, 16'h4700);
        issue_op("exact_m1p5x2_plus_0p5", 16'hBE00, 16'h4000, 16'h3800, 16'hC100);
        // back to back random stream
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_normal(a);
            random_normal(b);
            random_normal(c);
            issue_op($sformatf("random_%0d", i), a, b, c, fp16_mac_ref(a, b, c));
        end
        // 3.0 * 1.25 = 3.75, then minus itself
        issue_op("cancel_fixed", 16'h4200, 16'h3D00, 16'hC380, 16'h0000);
        c = fp16_mac_ref(16'h3E66, 16'hC0CD, 16'h0000) ^ 16'h8000;
        issue_op("cancel_model", 16'h3E66, 16'hC0CD, c, 16'h0000);
        issue_op("zero_pass", 16'h0000, 16'h4200, 16'h4500, 16'h4500);
        issue_op("subnormal_pass", 16'h0123, 16'h4000, 16'hC640, 16'hC640);
        issue_op("zero_all", 16'h0000, 16'h0000, 16'h0000, 16'h0000);
        // 60000 * 4, 40000 * 1 + 40000, 2^-14 squared
        issue_op("product_ovf", 16'h7B53, 16'h4400, 16'h3C00, 16'h7C00);
        issue_op("accum_ovf", 16'h78E2, 16'h3C00, 16'h78E2, 16'h7C00);
        issue_op("tiny_product", 16'h0400, 16'h0400, 16'h0000, 16'h0000);
        flush_accumulate();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, mac_unit_i.chk_i.fail_count);
        if (error_count == 0 && mac_unit_i.chk_i.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // result of the pair issued at edge k is read after edge k+3
    initial begin : compare_proc
        logic [15:0] expected;
        string       name;
        @(issue_started);
        repeat (3) @(posedge clk);
        forever begin
            @(negedge clk);
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                check_value(name, expected, out_accumulate);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== project.f ====
src/fp16_pkg.sv
src/mac_stage_pkg.sv
src/fp_mul_significand.sv
src/fp_mul_exponent.sv
src/fp_add_align.sv
src/fp_add_combine.sv
src/fp_add_normalize.sv
src/mac_unit.sv
bench/mac_unit_chk.sv
bench/tb_mac_unit.sv

// ==== src/fp16_pkg.sv ====
// binary16 field struct, field widths, exponent bias and special encodings
package fp16_pkg;

    // field widths of an IEEE binary16 number
    localparam int FP16_EXP_W  = 5;
    localparam int FP16_FRAC_W = 10;

    // biased exponent, value = 1.f * 2^(exp - bias)
    localparam int FP16_EXP_BIAS = 15;

    // all ones exponent, inf and nan live here
    localparam int FP16_EXP_MAX = 31;

    // significand with the hidden bit restored
    localparam int SIG_W = FP16_FRAC_W + 1;

    // significand plus two guard bits below the fraction
    localparam int EXT_W = SIG_W + 2;

    typedef struct packed {
        logic                   sign;
        logic [FP16_EXP_W-1:0]  exp;
        logic [FP16_FRAC_W-1:0] frac;
    } fp16_t;

    // saturation value on overflow, +infinity
    localparam fp16_t FP16_POS_INF = 16'h7C00;

    // every zero result leaves as +0
    localparam fp16_t FP16_POS_ZERO = 16'h0000;

endpackage

// ==== src/fp_add_align.sv ====
// add stage 1: exponent compare and right shift of the smaller operand
`timescale 1ns/1ps

module fp_add_align import fp16_pkg::*, mac_stage_pkg::*; (
    input  fp16_t        product,
    input  fp16_t        accum,
    input  logic         product_ovf,
    output align_stage_t stage
);

    add_operand_t          op_prod;
    add_operand_t          op_acc;
    logic                  prod_larger;
    logic [FP16_EXP_W-1:0] exp_diff;

    // zero exponent gives a zero significand, otherwise 1.f followed by guard bits
    assign op_prod.sign = product.sign;
    assign op_prod.sig  = (product.exp == '0) ? '0 : {1'b1, product.frac, 2'b00};
    assign op_acc.sign  = accum.sign;
    assign op_acc.sig   = (accum.exp == '0) ? '0 : {1'b1, accum.frac, 2'b00};

    // ties shift the accumulate operand
    assign prod_larger = product.exp >= accum.exp;
    assign exp_diff    = prod_larger ? (product.exp - accum.exp)
                                     : (accum.exp - product.exp);

    always_comb begin
        stage.product_ovf = product_ovf;
        if (prod_larger) begin
            stage.exp            = product.exp;
            stage.unshifted      = op_prod;
            stage.shifted.sign   = op_acc.sign;
            // bits pushed past the guard bits are lost
            stage.shifted.sig    = op_acc.sig >> exp_diff;
        end else begin
            stage.exp            = accum.exp;
            stage.unshifted      = op_acc;
            stage.shifted.sign   = op_prod.sign;
            stage.shifted.sig    = op_prod.sig >> exp_diff;
        end
    end

endmodule

// ==== src/fp_add_combine.sv ====
// add stage 2: signed-magnitude add or subtract of the aligned significands
`timescale 1ns/1ps

module fp_add_combine import fp16_pkg::*, mac_stage_pkg::*; (
    input  align_stage_t stage_in,
    output sum_stage_t   stage_out
);

    logic             same_sign;
    logic             shifted_larger;
    logic [EXT_W:0]   mag_sum;
    logic [EXT_W-1:0] mag_diff;

    assign same_sign      = stage_in.shifted.sign == stage_in.unshifted.sign;
    assign shifted_larger = stage_in.shifted.sig > stage_in.unshifted.sig;

    assign mag_sum  = {1'b0, stage_in.shifted.sig} + {1'b0, stage_in.unshifted.sig};
    // larger minus smaller, never negative
    assign mag_diff = shifted_larger ? (stage_in.shifted.sig - stage_in.unshifted.sig)
                                     : (stage_in.unshifted.sig - stage_in.shifted.sig);

    assign stage_out.sum   = same_sign ? mag_sum[EXT_W-1:0] : mag_diff;
    assign stage_out.carry = same_sign && mag_sum[EXT_W];
    // sign of the larger magnitude, equal magnitudes are cleaned up in the normalizer
    assign stage_out.sign  = (same_sign || !shifted_larger) ? stage_in.unshifted.sign
                                                            : stage_in.shifted.sign;
    assign stage_out.exp         = stage_in.exp;
    assign stage_out.product_ovf = stage_in.product_ovf;

endmodule

// ==== src/fp_add_normalize.sv ====
// add stage 3: leading-one normalize, truncate, exponent adjust and result flags
`timescale 1ns/1ps

module fp_add_normalize import fp16_pkg::*, mac_stage_pkg::*; (
    input  sum_stage_t stage,
    output fp16_t      result,
    output mac_flags_t flags
);

    logic [3:0]              lead_pos;
    logic [3:0]              shift;
    logic [EXT_W-1:0]        norm;
    logic signed [FP16_EXP_W+1:0] exp_adj;
    logic                    is_zero;
    logic                    ovf;
    logic                    unf;
    logic                    dropped;

    // priority search, the highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < EXT_W; i++) begin
            if (stage.sum[i]) begin
                lead_pos = 4'(i);
            end
        end
    end

    assign is_zero = (stage.sum == '0) && !stage.carry;
    assign shift   = stage.carry ? '0 : 4'(EXT_W - 1) - lead_pos;

    // carry means one right shift, otherwise move the leading one up to the hidden bit
    assign norm = stage.carry ? {1'b1, stage.sum[EXT_W-1:1]} : (stage.sum << shift);
    assign dropped = stage.carry ? (|stage.sum[2:0]) : (|norm[1:0]);

    // exp + carry - shift, signed so that underflow shows as <= 0
    assign exp_adj = {2'b00, stage.exp} + {{(FP16_EXP_W+1){1'b0}}, stage.carry}
                   - {3'b000, shift};
    assign ovf = !is_zero && (exp_adj >= $signed((FP16_EXP_W+2)'(FP16_EXP_MAX)));
    assign unf = !is_zero && (exp_adj <= $signed((FP16_EXP_W+2)'(0)));

    // overflowed results are replaced by +inf at the top level
    always_comb begin
        result.sign = stage.sign;
        result.exp  = exp_adj[FP16_EXP_W-1:0];
        // truncation, guard bits are just discarded
        result.frac = norm[EXT_W-2:2];
        if (is_zero || unf) begin
            result = FP16_POS_ZERO;
        end
    end

    assign flags.overflow  = ovf;
    assign flags.underflow = unf;
    assign flags.inexact   = !is_zero && (dropped || unf);

endmodule

// ==== src/fp_mul_exponent.sv ====
// multiply stage 2: product sign, biased exponent sum, overflow and underflow
`timescale 1ns/1ps

module fp_mul_exponent import fp16_pkg::*, mac_stage_pkg::*; (
    input  mul_stage_t stage,
    output fp16_t      product,
    output logic       ovf
);

    // wide enough for e1 + e2 + carry without wrap
    logic [FP16_EXP_W+1:0] exp_sum;
    logic [FP16_EXP_W+1:0] exp_unbiased;
    logic                  unf;

    assign exp_sum = {2'b00, stage.exp_a} + {2'b00, stage.exp_b}
                   + {{(FP16_EXP_W+1){1'b0}}, stage.carry};
    assign exp_unbiased = exp_sum - (FP16_EXP_W+2)'(FP16_EXP_BIAS);

    // range checks done on the biased sum so no signed math is needed
    assign unf = exp_sum <= (FP16_EXP_W+2)'(FP16_EXP_BIAS);
    assign ovf = !stage.zero
               && (exp_sum >= (FP16_EXP_W+2)'(FP16_EXP_MAX + FP16_EXP_BIAS));

    always_comb begin
        product.sign = stage.sign_a ^ stage.sign_b;
        // fraction below the hidden bit, guard bits dropped
        product.frac = stage.product[EXT_W-2:2];
        product.exp  = exp_unbiased[FP16_EXP_W-1:0];
        if (stage.zero || unf) begin
            product = FP16_POS_ZERO;
        end else if (ovf) begin
            // top level saturates anyway, keep the exponent pinned high
            product.exp = FP16_EXP_W'(FP16_EXP_MAX);
        end
    end

endmodule

// ==== src/fp_mul_significand.sv ====
// multiply stage 1: zero detect, sign and exponent split, 11x11 significand product
`timescale 1ns/1ps

module fp_mul_significand import fp16_pkg::*, mac_stage_pkg::*; (
    input  fp16_t      a,
    input  fp16_t      b,
    output mul_stage_t stage
);

    // hidden bits restored
    logic [SIG_W-1:0]   sig_a;
    logic [SIG_W-1:0]   sig_b;
    // full product, 2.20 fixed point
    logic [2*SIG_W-1:0] prod;

    assign sig_a = {1'b1, a.frac};
    assign sig_b = {1'b1, b.frac};
    assign prod  = sig_a * sig_b;

    assign stage.sign_a = a.sign;
    assign stage.sign_b = b.sign;
    assign stage.exp_a  = a.exp;
    assign stage.exp_b  = b.exp;

    // subnormals count as zero, exponent field 0 on either side
    assign stage.zero = (a.exp == '0) || (b.exp == '0);

    // top bit set means product in [2,4), take one bit higher and bump exponent later
    assign stage.carry   = prod[2*SIG_W-1];
    assign stage.product = prod[2*SIG_W-1] ? prod[2*SIG_W-1 -: EXT_W]
                                           : prod[2*SIG_W-2 -: EXT_W];

endmodule

// ==== src/mac_stage_pkg.sv ====
// packed structs between the mac pipeline stages and the normalizer flag struct
package mac_stage_pkg;
    import fp16_pkg::*;

    // multiplier stage 1 -> stage 2, register R1
    typedef struct packed {
        logic                  sign_a;
        logic                  sign_b;
        logic [FP16_EXP_W-1:0] exp_a;
        logic [FP16_EXP_W-1:0] exp_b;
        logic [EXT_W-1:0]      product;
        logic                  carry;
        logic                  zero;
    } mul_stage_t;

    // one signed-magnitude operand of the adder
    typedef struct packed {
        logic             sign;
        logic [EXT_W-1:0] sig;
    } add_operand_t;

    // after alignment, register R2
    typedef struct packed {
        add_operand_t          shifted;
        add_operand_t          unshifted;
        logic [FP16_EXP_W-1:0] exp;
        logic                  product_ovf;
    } align_stage_t;

    // after magnitude add or subtract, register R3
    typedef struct packed {
        logic                  sign;
        logic [EXT_W-1:0]      sum;
        logic                  carry;
        logic [FP16_EXP_W-1:0] exp;
        logic                  product_ovf;
    } sum_stage_t;

    typedef struct packed {
        logic overflow;
        logic underflow;
        logic inexact;
    } mac_flags_t;

endpackage

// ==== src/mac_unit.sv ====
// fp16 mac top level: multiply and accumulate stages, R1-R3 pipeline registers, saturation
`timescale 1ns/1ps

module mac_unit import fp16_pkg::*, mac_stage_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  fp16_t in_value,
    input  fp16_t weight,
    input  fp16_t in_accumulate,
    output fp16_t out_accumulate
);

    // R1: between the two multiply stages
    mul_stage_t   mul_d;
    mul_stage_t   mul_q;
    // R2: after alignment, in_accumulate joins here one cycle after its operands
    align_stage_t align_d;
    align_stage_t align_q;
    // R3: after the magnitude add
    sum_stage_t   sum_d;
    sum_stage_t   sum_q;

    fp16_t        product;
    logic         product_ovf;
    fp16_t        norm_result;
    mac_flags_t   flags;

    // multiply, stage 1
    fp_mul_significand mul_sig_i (
        .a     (in_value),
        .b     (weight),
        .stage (mul_d)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mul_q <= '0;
        end else begin
            mul_q <= mul_d;
        end
    end

    // multiply, stage 2
    fp_mul_exponent mul_exp_i (
        .stage   (mul_q),
        .product (product),
        .ovf     (product_ovf)
    );

    // accumulate, align
    fp_add_align align_i (
        .product     (product),
        .accum       (in_accumulate),
        .product_ovf (product_ovf),
        .stage       (align_d)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            align_q <= '0;
        end else begin
            align_q <= align_d;
        end
    end

    // accumulate, add
    fp_add_combine combine_i (
        .stage_in  (align_q),
        .stage_out (sum_d)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_d;
        end
    end

    // accumulate, normalize straight off R3
    fp_add_normalize normalize_i (
        .stage  (sum_q),
        .result (norm_result),
        .flags  (flags)
    );

    // overflow in either phase saturates to +inf
    assign out_accumulate = (flags.overflow || sum_q.product_ovf) ? FP16_POS_INF
                                                                  : norm_result;

endmodule
